//--- verilog/sm83_pkg.sv
package sm83_pkg;

	localparam int WORD_SIZE = 8;
	localparam int ADR_WIDTH = 2 * WORD_SIZE;
	localparam int T_PER_M   = 4;

	typedef logic [WORD_SIZE-1:0]        word_t;
	typedef logic [ADR_WIDTH-1:0]        adr_t;
	typedef logic [2:0]                  reg_sel_t;
	typedef logic [2:0]                  alu_op_t;
	typedef logic [3:0]                  flags_t;
	typedef logic [1:0]                  adr_src_t;
	typedef logic [1:0]                  data_src_t;
	typedef logic [$clog2(T_PER_M)-1:0] phase_t;

	// register field of the opcode, as it appears in bits 5..3 and 2..0.
	localparam reg_sel_t REG_B   = 3'd0;
	localparam reg_sel_t REG_C   = 3'd1;
	localparam reg_sel_t REG_D   = 3'd2;
	localparam reg_sel_t REG_E   = 3'd3;
	localparam reg_sel_t REG_H   = 3'd4;
	localparam reg_sel_t REG_L   = 3'd5;
	localparam reg_sel_t REG_MEM = 3'd6;
	localparam reg_sel_t REG_A   = 3'd7;

	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_ADC = 3'd1;
	localparam alu_op_t ALU_SUB = 3'd2;
	localparam alu_op_t ALU_SBC = 3'd3;
	localparam alu_op_t ALU_AND = 3'd4;
	localparam alu_op_t ALU_XOR = 3'd5;
	localparam alu_op_t ALU_OR  = 3'd6;
	localparam alu_op_t ALU_CP  = 3'd7;

	// bit positions inside flags_t, which maps onto f[7:4].
	localparam int FLAG_Z = 3;
	localparam int FLAG_N = 2;
	localparam int FLAG_H = 1;
	localparam int FLAG_C = 0;

	localparam adr_src_t ASRC_PC = 2'd0;
	localparam adr_src_t ASRC_HL = 2'd1;
	localparam adr_src_t ASRC_WZ = 2'd2;

	localparam data_src_t DSRC_DIN = 2'd0;
	localparam data_src_t DSRC_REG = 2'd1;
	localparam data_src_t DSRC_ALU = 2'd2;

	localparam word_t OP_NOP = 8'h00;
	localparam word_t OP_JP  = 8'hc3;

endpackage

//--- verilog/sm83_ctl_if.sv
`timescale 1ns/10ps

interface sm83_ctl_if;
	// one-hot machine cycle phase.
	logic                  t1, t2, t3, t4;

	sm83_pkg::reg_sel_t    rd_sel;
	sm83_pkg::reg_sel_t    wr_sel;
	logic                  reg_we;
	logic                  a_we;
	logic                  wz_lo_we;
	logic                  wz_hi_we;
	logic                  pc_we;

	sm83_pkg::adr_src_t    adr_src;
	sm83_pkg::data_src_t   data_src;
	sm83_pkg::alu_op_t     alu_op;
	logic                  alu_en;
	logic                  inc_en;

	logic                  mread;
	logic                  mwrite;
	logic                  ir_we;
	logic                  ifetch;

	modport control(
		output t1, t2, t3, t4,
		output rd_sel, wr_sel, reg_we, a_we, wz_lo_we, wz_hi_we, pc_we,
		output adr_src, data_src, alu_op, alu_en, inc_en,
		output mread, mwrite, ir_we, ifetch
	);

	modport datapath(
		input t1, t2, t3, t4,
		input rd_sel, wr_sel, reg_we, a_we, wz_lo_we, wz_hi_we, pc_we,
		input adr_src, data_src, alu_op, alu_en, inc_en,
		input mread, mwrite, ir_we, ifetch
	);
endinterface

//--- verilog/sm83_control.sv
`timescale 1ns/10ps

module sm83_control(
	input  logic            clk,
	input  logic            reset,
	input  sm83_pkg::word_t opcode,
	sm83_ctl_if.control     ctl
);

	typedef enum logic [2:0] {
		FETCH,
		OPERAND,
		OPERAND_HI,
		MEM,
		JUMP
	} state_t;

	state_t             state;
	state_t             next_state;
	sm83_pkg::phase_t   phase;
	logic               last_t;
	sm83_pkg::reg_sel_t dst;
	sm83_pkg::reg_sel_t src;
	logic               is_ld_rn;
	logic               is_ld_rr;
	logic               is_alu_r;
	logic               is_alu_n;
	logic               is_jp;

	always_ff @(posedge clk) begin
		if (reset)
			phase <= '0;
		else if (last_t)
			phase <= '0;
		else
			phase <= phase + 1'b1;
	end

	assign last_t = phase == sm83_pkg::phase_t'(sm83_pkg::T_PER_M - 1);

	assign ctl.t1 = phase == sm83_pkg::phase_t'(0);
	assign ctl.t2 = phase == sm83_pkg::phase_t'(1);
	assign ctl.t3 = phase == sm83_pkg::phase_t'(2);
	assign ctl.t4 = last_t;

	always_ff @(posedge clk) begin
		if (reset)
			state <= FETCH;
		else if (last_t)
			state <= next_state;
	end

	// the instruction register only holds the new opcode from the end of t3 of the fetch.
	assign dst      = opcode[5:3];
	assign src      = opcode[2:0];
	assign is_ld_rn = opcode[7:6] == 2'b00 && src == sm83_pkg::REG_MEM;
	assign is_ld_rr = opcode[7:6] == 2'b01 &&
	                  !(dst == sm83_pkg::REG_MEM && src == sm83_pkg::REG_MEM);
	assign is_alu_r = opcode[7:6] == 2'b10;
	assign is_alu_n = opcode[7:6] == 2'b11 && src == sm83_pkg::REG_MEM;
	assign is_jp    = opcode == sm83_pkg::OP_JP;

	always_comb begin
		ctl.rd_sel   = src;
		ctl.wr_sel   = dst;
		ctl.reg_we   = 1'b0;
		ctl.a_we     = 1'b0;
		ctl.wz_lo_we = 1'b0;
		ctl.wz_hi_we = 1'b0;
		ctl.pc_we    = 1'b0;
		ctl.adr_src  = sm83_pkg::ASRC_PC;
		ctl.data_src = sm83_pkg::DSRC_DIN;
		ctl.alu_op   = opcode[5:3];
		ctl.alu_en   = 1'b0;
		ctl.inc_en   = 1'b0;
		ctl.mread    = 1'b0;
		ctl.mwrite   = 1'b0;
		ctl.ir_we    = 1'b0;
		ctl.ifetch   = 1'b0;
		next_state   = FETCH;

		case (state)
			FETCH: begin
				ctl.mread  = 1'b1;
				ctl.ifetch = 1'b1;
				ctl.ir_we  = 1'b1;
				ctl.inc_en = 1'b1;
				ctl.pc_we  = last_t;
				if (last_t) begin
					if (opcode == sm83_pkg::OP_NOP) begin
						next_state = FETCH;
					end else if (is_ld_rn || is_alu_n || is_jp) begin
						next_state = OPERAND;
					end else if (is_ld_rr &&
					             (dst == sm83_pkg::REG_MEM || src == sm83_pkg::REG_MEM)) begin
						next_state = MEM;
					end else if (is_ld_rr) begin
						ctl.reg_we   = 1'b1;
						ctl.data_src = sm83_pkg::DSRC_REG;
					end else if (is_alu_r && src == sm83_pkg::REG_MEM) begin
						next_state = MEM;
					end else if (is_alu_r) begin
						ctl.alu_en   = 1'b1;
						ctl.a_we     = 1'b1;
						ctl.data_src = sm83_pkg::DSRC_ALU;
					end
				end
			end
			OPERAND: begin
				ctl.mread  = 1'b1;
				ctl.inc_en = 1'b1;
				ctl.pc_we  = last_t;
				if (is_jp) begin
					ctl.wz_lo_we = last_t;
					next_state   = OPERAND_HI;
				end else if (is_ld_rn && dst == sm83_pkg::REG_MEM) begin
					// the immediate stays in the data latch for the store cycle.
					next_state = MEM;
				end else if (is_ld_rn) begin
					ctl.reg_we = last_t;
				end else begin
					ctl.alu_en   = 1'b1;
					ctl.a_we     = last_t;
					ctl.data_src = sm83_pkg::DSRC_ALU;
				end
			end
			OPERAND_HI: begin
				ctl.mread    = 1'b1;
				ctl.inc_en   = 1'b1;
				ctl.pc_we    = last_t;
				ctl.wz_hi_we = last_t;
				next_state   = JUMP;
			end
			JUMP: begin
				ctl.adr_src = sm83_pkg::ASRC_WZ;
				ctl.pc_we   = last_t;
			end
			MEM: begin
				ctl.adr_src = sm83_pkg::ASRC_HL;
				if (is_ld_rn) begin
					ctl.mwrite = 1'b1;
				end else if (is_ld_rr && dst == sm83_pkg::REG_MEM) begin
					ctl.mwrite   = 1'b1;
					ctl.data_src = sm83_pkg::DSRC_REG;
				end else if (is_ld_rr) begin
					ctl.mread  = 1'b1;
					ctl.reg_we = last_t;
				end else begin
					ctl.mread    = 1'b1;
					ctl.alu_en   = 1'b1;
					ctl.a_we     = last_t;
					ctl.data_src = sm83_pkg::DSRC_ALU;
				end
			end
			default: begin
				next_state = FETCH;
			end
		endcase
	end

endmodule

//--- verilog/sm83_alu.sv
`timescale 1ns/10ps

module sm83_alu(
	input  logic              clk,
	input  logic              reset,
	sm83_ctl_if.datapath      ctl,
	input  sm83_pkg::word_t   op_a,
	input  sm83_pkg::word_t   op_b,
	output sm83_pkg::word_t   result,
	output sm83_pkg::flags_t  flags
);

	logic             carry_in;
	logic             subtract;
	logic [4:0]       nibble;
	logic [8:0]       full;
	sm83_pkg::flags_t next_flags;

	assign carry_in = (ctl.alu_op == sm83_pkg::ALU_ADC || ctl.alu_op == sm83_pkg::ALU_SBC) &&
	                  flags[sm83_pkg::FLAG_C];
	assign subtract = ctl.alu_op inside {sm83_pkg::ALU_SUB, sm83_pkg::ALU_SBC, sm83_pkg::ALU_CP};

	// bit 4 of the low nibble sum is the half carry, or the half borrow when subtracting.
	always_comb begin
		if (subtract) begin
			nibble = {1'b0, op_a[3:0]} - {1'b0, op_b[3:0]} - {4'b0000, carry_in};
			full   = {1'b0, op_a} - {1'b0, op_b} - {8'h00, carry_in};
		end else begin
			nibble = {1'b0, op_a[3:0]} + {1'b0, op_b[3:0]} + {4'b0000, carry_in};
			full   = {1'b0, op_a} + {1'b0, op_b} + {8'h00, carry_in};
		end
	end

	always_comb begin
		next_flags = '0;
		case (ctl.alu_op)
			sm83_pkg::ALU_AND: begin
				result                     = op_a & op_b;
				next_flags[sm83_pkg::FLAG_H] = 1'b1;
			end
			sm83_pkg::ALU_XOR: begin
				result = op_a ^ op_b;
			end
			sm83_pkg::ALU_OR: begin
				result = op_a | op_b;
			end
			default: begin
				result                       = full[7:0];
				next_flags[sm83_pkg::FLAG_N] = subtract;
				next_flags[sm83_pkg::FLAG_H] = nibble[4];
				next_flags[sm83_pkg::FLAG_C] = full[8];
			end
		endcase
		next_flags[sm83_pkg::FLAG_Z] = result == '0;
	end

	always_ff @(posedge clk) begin
		if (reset)
			flags <= '0;
		else if (ctl.alu_en && ctl.t4)
			flags <= next_flags;
	end

endmodule

//--- verilog/sm83_adr_inc.sv
`timescale 1ns/10ps

module sm83_adr_inc(
	input  logic           clk,
	sm83_ctl_if.datapath   ctl,
	input  sm83_pkg::adr_t ain,
	output sm83_pkg::adr_t aout
);

	sm83_pkg::adr_t latch;
	sm83_pkg::adr_t next_adr;

	// the latch holds the address of the running machine cycle.
	always_ff @(posedge clk) begin
		if (ctl.t1)
			latch <= ain;
	end

	assign next_adr = latch + sm83_pkg::adr_t'(1);

	// pc samples this at the end of t4. without inc_en the latch passes as is,
	// which is how a jump moves wz into pc.
	always_comb begin
		if (ctl.t4 && ctl.inc_en)
			aout = next_adr;
		else
			aout = latch;
	end

endmodule

//--- verilog/sm83_io.sv
`timescale 1ns/10ps

module sm83_io(
	input  logic            clk,
	input  logic            reset,
	sm83_ctl_if.datapath    ctl,
	input  sm83_pkg::adr_t  ain,
	input  sm83_pkg::word_t wdata,
	output sm83_pkg::word_t rdata,
	output sm83_pkg::word_t opcode,
	output sm83_pkg::adr_t  adr,
	input  sm83_pkg::word_t din,
	output sm83_pkg::word_t dout,
	output logic            p_rd,
	output logic            p_wr
);

	always_ff @(posedge clk) begin
		if (ctl.t1) begin
			adr <= ain;
			if (ctl.mwrite)
				dout <= wdata;
		end
		// memory answers by the end of t3.
		if (ctl.t3 && ctl.mread) begin
			rdata <= din;
			if (ctl.ir_we)
				opcode <= din;
		end
	end

	// read strobe covers t2 and t3, write strobe only t3.
	always_ff @(posedge clk) begin
		if (reset) begin
			p_rd <= 1'b0;
			p_wr <= 1'b0;
		end else begin
			if (ctl.t1)
				p_rd <= ctl.mread;
			else if (ctl.t3)
				p_rd <= 1'b0;
			if (ctl.t2)
				p_wr <= ctl.mwrite;
			else if (ctl.t3)
				p_wr <= 1'b0;
		end
	end

endmodule

//--- verilog/sm83.sv
`timescale 1ns/10ps

module sm83(
	input  logic            clk,
	input  logic            reset,
	output sm83_pkg::adr_t  adr,
	input  sm83_pkg::word_t din,
	output sm83_pkg::word_t dout,
	output logic            p_rd,
	output logic            p_wr,
	output logic            dbg_ifetch,
	output sm83_pkg::adr_t  dbg_pc,
	output sm83_pkg::adr_t  dbg_bc,
	output sm83_pkg::adr_t  dbg_de,
	output sm83_pkg::adr_t  dbg_hl,
	output sm83_pkg::adr_t  dbg_af
);

	sm83_ctl_if ctl_bus();

	sm83_pkg::word_t  reg_b, reg_c, reg_d, reg_e, reg_h, reg_l, reg_a;
	sm83_pkg::word_t  reg_w, reg_z;
	sm83_pkg::adr_t   reg_pc;
	sm83_pkg::word_t  opcode;
	sm83_pkg::word_t  rdata;
	sm83_pkg::word_t  reg_rd;
	sm83_pkg::word_t  data_bus;
	sm83_pkg::word_t  alu_result;
	sm83_pkg::flags_t flags;
	sm83_pkg::adr_t   ain;
	sm83_pkg::adr_t   aout;
	logic             a_load;

	sm83_control control_i(
		.clk,
		.reset,
		.opcode,
		.ctl(ctl_bus)
	);

	sm83_alu alu_i(
		.clk,
		.reset,
		.ctl(ctl_bus),
		.op_a(reg_a),
		.op_b(reg_rd),
		.result(alu_result),
		.flags
	);

	sm83_adr_inc adr_inc_i(
		.clk,
		.ctl(ctl_bus),
		.ain,
		.aout
	);

	sm83_io io_i(
		.clk,
		.reset,
		.ctl(ctl_bus),
		.ain,
		.wdata(data_bus),
		.rdata,
		.opcode,
		.adr,
		.din,
		.dout,
		.p_rd,
		.p_wr
	);

	// the (hl) slot of the register field reads the data latch.
	always_comb begin
		case (ctl_bus.rd_sel)
			sm83_pkg::REG_B:   reg_rd = reg_b;
			sm83_pkg::REG_C:   reg_rd = reg_c;
			sm83_pkg::REG_D:   reg_rd = reg_d;
			sm83_pkg::REG_E:   reg_rd = reg_e;
			sm83_pkg::REG_H:   reg_rd = reg_h;
			sm83_pkg::REG_L:   reg_rd = reg_l;
			sm83_pkg::REG_MEM: reg_rd = rdata;
			default:           reg_rd = reg_a;
		endcase
	end

	always_comb begin
		case (ctl_bus.data_src)
			sm83_pkg::DSRC_REG: data_bus = reg_rd;
			sm83_pkg::DSRC_ALU: data_bus = alu_result;
			default:            data_bus = rdata;
		endcase
	end

	always_comb begin
		case (ctl_bus.adr_src)
			sm83_pkg::ASRC_HL: ain = {reg_h, reg_l};
			sm83_pkg::ASRC_WZ: ain = {reg_w, reg_z};
			default:           ain = reg_pc;
		endcase
	end

	// cp only sets the flags.
	assign a_load = ctl_bus.a_we && ctl_bus.alu_op != sm83_pkg::ALU_CP;

	always_ff @(posedge clk) begin
		if (ctl_bus.reg_we) begin
			case (ctl_bus.wr_sel)
				sm83_pkg::REG_B: reg_b <= data_bus;
				sm83_pkg::REG_C: reg_c <= data_bus;
				sm83_pkg::REG_D: reg_d <= data_bus;
				sm83_pkg::REG_E: reg_e <= data_bus;
				sm83_pkg::REG_H: reg_h <= data_bus;
				sm83_pkg::REG_L: reg_l <= data_bus;
				sm83_pkg::REG_A: reg_a <= data_bus;
				default: ;
			endcase
		end
		if (a_load)
			reg_a <= data_bus;
		if (ctl_bus.wz_lo_we)
			reg_z <= data_bus;
		if (ctl_bus.wz_hi_we)
			reg_w <= data_bus;
	end

	always_ff @(posedge clk) begin
		if (reset)
			reg_pc <= '0;
		else if (ctl_bus.pc_we)
			reg_pc <= aout;
	end

	assign dbg_ifetch = ctl_bus.ifetch && p_rd;
	assign dbg_pc     = reg_pc;
	assign dbg_bc     = {reg_b, reg_c};
	assign dbg_de     = {reg_d, reg_e};
	assign dbg_hl     = {reg_h, reg_l};
	assign dbg_af     = {reg_a, flags, 4'b0000};

endmodule

//--- dv/sm83_tb_mem.sv
`timescale 1ns/10ps

module sm83_tb_mem(
	input  logic            clk,
	input  sm83_pkg::adr_t  adr,
	output sm83_pkg::word_t rdata,
	input  sm83_pkg::word_t wdata,
	input  logic            wr,
	input  logic            load_en,
	input  sm83_pkg::adr_t  load_adr,
	input  sm83_pkg::word_t load_data,
	input  logic            clear_log,
	output int              write_count,
	output sm83_pkg::adr_t  write_adr,
	output sm83_pkg::word_t write_data
);

	sm83_pkg::word_t mem [0:65535];

	// background pattern mixes both address bytes so aliasing shows up.
	initial begin
		for (int i = 0; i < 65536; i++)
			mem[i] = sm83_pkg::word_t'(i[7:0] ^ i[15:8] ^ 8'h5a);
	end

	assign rdata = mem[adr];

	always @(posedge clk) begin
		if (load_en)
			mem[load_adr] <= load_data;
		if (wr)
			mem[adr] <= wdata;
		if (clear_log) begin
			write_count <= 0;
		end else if (wr) begin
			write_count <= write_count + 1;
			write_adr   <= adr;
			write_data  <= wdata;
		end
	end

endmodule

//--- dv/sm83_tb.sv
`timescale 1ns/10ps

module sm83_tb;

	localparam int N_CASES = 24;

	typedef struct packed {
		sm83_pkg::word_t   a;
		sm83_pkg::word_t   b;
		sm83_pkg::alu_op_t op;
		logic              imm;
		logic              cin;
		sm83_pkg::adr_t    st;
		sm83_pkg::adr_t    exp_af;
	} case_t;

	logic clk = 1'b0;
	logic reset;
	logic load_en;
	logic clear_log;
	sm83_pkg::adr_t  load_adr;
	sm83_pkg::word_t load_data;
	sm83_pkg::adr_t  adr;
	sm83_pkg::word_t din;
	sm83_pkg::word_t dout;
	logic p_rd;
	logic p_wr;
	logic dbg_ifetch;
	sm83_pkg::adr_t dbg_pc, dbg_bc, dbg_de, dbg_hl, dbg_af;
	int             write_count;
	sm83_pkg::adr_t  write_adr;
	sm83_pkg::word_t write_data;

	case_t           cases [N_CASES];
	sm83_pkg::word_t prog[$];
	sm83_pkg::adr_t  exp_fetch[$];
	sm83_pkg::adr_t  fetch_adr[$];
	int              fetch_cyc[$];
	sm83_pkg::adr_t  loop_adr;
	int              jp_hits = 0;
	int              cycle = 0;
	logic            prev_fetch = 1'b0;
	logic            reset_d = 1'b0;
	int              checks = 0;
	int              errors = 0;
	int              seed = 32'h56693364;

	sm83 dut_i(
		.clk,
		.reset,
		.adr,
		.din,
		.dout,
		.p_rd,
		.p_wr,
		.dbg_ifetch,
		.dbg_pc,
		.dbg_bc,
		.dbg_de,
		.dbg_hl,
		.dbg_af
	);

	sm83_tb_mem mem_i(
		.clk,
		.adr,
		.rdata(din),
		.wdata(dout),
		.wr(p_wr),
		.load_en,
		.load_adr,
		.load_data,
		.clear_log,
		.write_count,
		.write_adr,
		.write_data
	);

	always #10 clk = ~clk;

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t ns: %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// returns a and f the way dbg_af shows them. cp leaves a as it was.
	function automatic sm83_pkg::adr_t ref_alu(input sm83_pkg::alu_op_t op,
	                                           input sm83_pkg::word_t a,
	                                           input sm83_pkg::word_t b,
	                                           input logic cin);
		int              ci;
		int              sum;
		int              lo;
		sm83_pkg::word_t r;
		logic            n, h, c;
		ci = (op == sm83_pkg::ALU_ADC || op == sm83_pkg::ALU_SBC) ? int'(cin) : 0;
		n = 1'b0;
		h = 1'b0;
		c = 1'b0;
		case (op)
			sm83_pkg::ALU_ADD, sm83_pkg::ALU_ADC: begin
				sum = int'(a) + int'(b) + ci;
				lo  = int'(a[3:0]) + int'(b[3:0]) + ci;
				r   = sum[7:0];
				h   = lo > 15;
				c   = sum > 255;
			end
			sm83_pkg::ALU_AND: begin
				r = a & b;
				h = 1'b1;
			end
			sm83_pkg::ALU_XOR: r = a ^ b;
			sm83_pkg::ALU_OR:  r = a | b;
			default: begin
				sum = int'(a) - int'(b) - ci;
				r   = sum[7:0];
				n   = 1'b1;
				h   = int'(a[3:0]) < int'(b[3:0]) + ci;
				c   = int'(a) < int'(b) + ci;
			end
		endcase
		return {(op == sm83_pkg::ALU_CP) ? a : r, r == 8'h00, n, h, c, 4'h0};
	endfunction

	task automatic emit(input sm83_pkg::word_t b);
		prog.push_back(b);
	endtask

	task automatic mark_fetch();
		exp_fetch.push_back(sm83_pkg::adr_t'(prog.size()));
	endtask

	task automatic build_program(input case_t c);
		prog.delete();
		exp_fetch.delete();
		// ADD FF+01 leaves the carry set for ADC and SBC.
		if (c.cin) begin
			mark_fetch();
			emit(8'h3e);
			emit(8'hff);
			mark_fetch();
			emit(8'hc6);
			emit(8'h01);
		end
		mark_fetch();
		emit(8'h3e);
		emit(c.a);
		mark_fetch();
		emit(8'h06);
		emit(c.b);
		mark_fetch();
		if (c.imm) begin
			emit(8'hc6 | {2'b00, c.op, 3'b000});
			emit(c.b);
		end else begin
			emit(8'h80 | {2'b00, c.op, 3'b000});
		end
		mark_fetch();
		emit(8'h26);
		emit(c.st[15:8]);
		mark_fetch();
		emit(8'h2e);
		emit(c.st[7:0]);
		mark_fetch();
		emit(8'h77);
		mark_fetch();
		emit(8'h4e);
		// ld d,a and ld e,b copy between registers without the bus.
		mark_fetch();
		emit(8'h57);
		mark_fetch();
		emit(8'h58);
		mark_fetch();
		emit(8'h10);
		loop_adr = sm83_pkg::adr_t'(prog.size());
		mark_fetch();
		emit(sm83_pkg::OP_JP);
		emit(loop_adr[7:0]);
		emit(loop_adr[15:8]);
		exp_fetch.push_back(loop_adr);
	endtask

	task automatic run_case(input int idx);
		case_t           c;
		sm83_pkg::word_t exp_a;
		int              k;
		c = cases[idx];
		build_program(c);
		exp_a = c.exp_af[15:8];
		@(negedge clk);
		reset     = 1'b1;
		clear_log = 1'b1;
		for (int i = 0; i < prog.size(); i++) begin
			load_en   = 1'b1;
			load_adr  = sm83_pkg::adr_t'(i);
			load_data = prog[i];
			@(negedge clk);
		end
		load_en = 1'b0;
		repeat (3) @(negedge clk);
		clear_log = 1'b0;
		fetch_adr.delete();
		fetch_cyc.delete();
		jp_hits = 0;
		reset   = 1'b0;
		while (jp_hits < 2)
			@(negedge clk);

		check("A and flags", dbg_af, c.exp_af);
		check("BC", dbg_bc, {c.b, exp_a});
		check("DE", dbg_de, {exp_a, c.b});
		check("HL", dbg_hl, c.st);
		check("PC", dbg_pc, loop_adr);
		check("write count", write_count, 1);
		check("write address", write_adr, c.st);
		check("write data", write_data, exp_a);
		check("fetch count ok", fetch_adr.size() >= exp_fetch.size(), 1);
		for (int i = 0; i < exp_fetch.size() && i < fetch_adr.size(); i++)
			check("fetch address", fetch_adr[i], exp_fetch[i]);
		k = exp_fetch.size() - 3;
		if (fetch_cyc.size() > k + 2) begin
			check("clocks after unsupported opcode", fetch_cyc[k + 1] - fetch_cyc[k], 4);
			check("clocks per jump loop", fetch_cyc[k + 2] - fetch_cyc[k + 1], 16);
		end
	endtask

	// bus watcher, sampling registered outputs at the rising edge.
	always @(posedge clk) begin
		cycle++;
		if (reset_d) begin
			check("p_rd around reset", p_rd, 0);
			check("p_wr around reset", p_wr, 0);
			check("dbg_ifetch around reset", dbg_ifetch, 0);
		end
		if (p_wr && dbg_ifetch)
			check("p_wr during fetch", 1, 0);
		if (dbg_ifetch && !prev_fetch && !reset) begin
			if (fetch_adr.size() == 0)
				check("first fetch address", adr, 16'h0000);
			fetch_adr.push_back(adr);
			fetch_cyc.push_back(cycle);
			if (adr == loop_adr)
				jp_hits++;
		end
		prev_fetch = dbg_ifetch;
		reset_d    = reset;
	end

	initial begin
		#(N_CASES * 40 * 4 * 20);
		$display("The run timed out before all test cases finished.");
		$display("Testbench failed");
		$finish;
	end

	initial begin
		logic [31:0] v;
		logic [31:0] w;
		reset     = 1'b1;
		clear_log = 1'b1;
		load_en   = 1'b0;
		load_adr  = '0;
		load_data = '0;
		loop_adr  = 16'hffff;
		cases[0]  = '{8'h0f, 8'h01, sm83_pkg::ALU_ADD, 1'b0, 1'b0, 16'h8000, 16'h1020};
		cases[1]  = '{8'hf0, 8'h10, sm83_pkg::ALU_ADD, 1'b1, 1'b0, 16'h8123, 16'h0090};
		cases[2]  = '{8'h0e, 8'h01, sm83_pkg::ALU_ADC, 1'b0, 1'b1, 16'h9001, 16'h1020};
		cases[3]  = '{8'h42, 8'h42, sm83_pkg::ALU_SUB, 1'b0, 1'b0, 16'ha5a5, 16'h00c0};
		cases[4]  = '{8'h10, 8'h20, sm83_pkg::ALU_SUB, 1'b1, 1'b0, 16'hc000, 16'hf050};
		cases[5]  = '{8'h10, 8'h0f, sm83_pkg::ALU_SBC, 1'b0, 1'b1, 16'hfffe, 16'h00e0};
		cases[6]  = '{8'hf0, 8'h0f, sm83_pkg::ALU_AND, 1'b0, 1'b0, 16'h8400, 16'h00a0};
		cases[7]  = '{8'haa, 8'haa, sm83_pkg::ALU_XOR, 1'b1, 1'b0, 16'hb00b, 16'h0080};
		cases[8]  = '{8'h00, 8'h00, sm83_pkg::ALU_OR,  1'b0, 1'b0, 16'h8800, 16'h0080};
		cases[9]  = '{8'h81, 8'h18, sm83_pkg::ALU_OR,  1'b1, 1'b1, 16'hd0d0, 16'h9900};
		cases[10] = '{8'h5a, 8'h5a, sm83_pkg::ALU_CP,  1'b1, 1'b0, 16'he123, 16'h5ac0};
		cases[11] = '{8'h01, 8'h02, sm83_pkg::ALU_CP,  1'b0, 1'b1, 16'hffff, 16'h0170};
		for (int i = 12; i < N_CASES; i++) begin
			v = $random(seed);
			w = $random(seed);
			cases[i] = '{v[7:0], v[15:8], v[18:16], v[19], v[20], {1'b1, w[14:0]}, 16'h0000};
			cases[i].exp_af = ref_alu(cases[i].op, cases[i].a, cases[i].b, cases[i].cin);
		end
		repeat (3) @(negedge clk);
		for (int i = 0; i < N_CASES; i++)
			run_case(i);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- build.f
verilog/sm83_pkg.sv
verilog/sm83_ctl_if.sv
verilog/sm83_control.sv
verilog/sm83_alu.sv
verilog/sm83_adr_inc.sv
verilog/sm83_io.sv
verilog/sm83.sv
dv/sm83_tb_mem.sv
dv/sm83_tb.sv

//--- Makefile
# Verilator build and run of the SM83 core testbench.

LOG := sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f build.f --top-module sm83_tb \
		-Mdir obj_dir -o sm83_tb

run: compile
	./obj_dir/sm83_tb > $(LOG) 2>&1; cat $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
